/* src/dcache_pkg.sv */
/*
 * data cache shared definitions
 *   geometry constants for the two-way, eight-set cache
 *   vector types for address fields, ways and the flush walk
 *   controller state encoding
 */

package dcache_pkg;

    // geometry
    localparam int NUM_SETS  = 8;
    localparam int NUM_WAYS  = 2;
    localparam int BLK_WORDS = 2;

    // data word or byte address
    typedef logic [31:0] word_t;

    // address fields: tag 31..6, index 5..3, word select 2
    typedef logic [25:0] tag_t;
    typedef logic [2:0]  idx_t;
    typedef logic        blk_t;

    typedef logic        way_t;

    // bits 2..0 set, bit 3 way, bit 4 walk done
    typedef logic [4:0]  flush_idx_t;

    typedef enum logic [3:0] {
        IDLE,
        WB_WORD0,
        WB_WORD1,
        LOAD_WORD0,
        LOAD_WORD1,
        FLUSH_CHECK,
        FLUSH_WORD0,
        FLUSH_WORD1,
        HALTED
    } ctrl_state_t;

endpackage

/* src/dcache_lookup.sv */
/*
 * data cache lookup stage
 *   splits the request address into tag, index and word select
 *   tag match on both ways of the selected set
 *   hit way, LRU victim and addressed read word
 */

`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
    input  word_t         dmem_addr,
    input  logic [1:0]    set_valid,
    input  logic [1:0]    set_dirty,
    input  tag_t          set_tag0,
    input  tag_t          set_tag1,
    input  way_t          set_lru,
    input  word_t [3:0]   set_data,
    output logic          hit,
    output way_t          hit_way,
    output way_t          victim_way,
    output logic          victim_dirty,
    output tag_t          victim_tag,
    output idx_t          idx,
    output blk_t          blk,
    output tag_t          req_tag,
    output word_t         read_word
);

    logic match0;
    logic match1;

    // low two bits are the byte offset and drop out here
    assign req_tag = dmem_addr[31:6];
    assign idx     = dmem_addr[5:3];
    assign blk     = dmem_addr[2];

    assign match0 = set_valid[0] && (set_tag0 == req_tag);
    assign match1 = set_valid[1] && (set_tag1 == req_tag);

    assign hit = match0 || match1;

    // way 0 wins when both match
    assign hit_way = match0 ? 1'b0 : 1'b1;

    // least recently used way gets replaced
    assign victim_way   = set_lru;
    assign victim_dirty = set_dirty[victim_way];
    assign victim_tag   = victim_way ? set_tag1 : set_tag0;

    // way-major, word-minor packing of the set
    assign read_word = set_data[{hit_way, blk}];

endmodule

/* src/dcache_ctrl.sv */
/*
 * data cache controller
 *   FSM for hits, victim write-back, refill and the halt flush
 *   flush walk counter over all sixteen frames
 *   memory port outputs and store write strobes
 */

`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       dmem_ren,
    input  logic       dmem_wen,
    input  logic       halt,
    input  logic       hit,
    input  way_t       hit_way,
    input  way_t       victim_way,
    input  logic       victim_dirty,
    input  tag_t       victim_tag,
    input  tag_t       req_tag,
    input  idx_t       idx,
    input  word_t      read_word,
    input  word_t      dmem_store,
    input  word_t      mem_load,
    input  logic       mem_wait,
    input  logic       flush_dirty,
    input  tag_t       flush_tag,
    input  word_t      flush_data0,
    input  word_t      flush_data1,
    input  word_t      victim_data0,
    input  word_t      victim_data1,
    output logic       dhit,
    output logic       flushed,
    output word_t      dmem_load,
    output logic       mem_ren,
    output logic       mem_wen,
    output word_t      mem_addr,
    output word_t      mem_store,
    output logic       fill_en,
    output blk_t       fill_word,
    output word_t      fill_data,
    output logic       cpu_wr_en,
    output logic       cpu_wr_is_read,
    output way_t       wr_way,
    output flush_idx_t flush_idx,
    output logic       flush_clean
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    flush_idx_t  next_flush_idx;

    logic        req;
    logic        xfer_done;
    idx_t        flush_set;

    // word address of one word of a block
    function automatic word_t block_addr(tag_t t, idx_t i, blk_t w);
        return {t, i, w, 2'b00};
    endfunction

    assign req       = dmem_ren || dmem_wen;
    assign xfer_done = !mem_wait;
    assign flush_set = flush_idx[2:0];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_idx <= '0;
        end else begin
            state     <= next_state;
            flush_idx <= next_flush_idx;
        end
    end

    always_comb begin
        next_state     = state;
        next_flush_idx = flush_idx;
        dhit           = 1'b0;
        flushed        = 1'b0;
        dmem_load      = '0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = '0;
        mem_store      = '0;
        fill_en        = 1'b0;
        fill_word      = 1'b0;
        fill_data      = mem_load;
        cpu_wr_en      = 1'b0;
        cpu_wr_is_read = dmem_ren;
        wr_way         = victim_way;
        flush_clean    = 1'b0;

        case (state)
            IDLE: begin
                if (req && hit) begin
                    // hit completes here, array updates on this edge
                    dhit      = 1'b1;
                    dmem_load = read_word;
                    cpu_wr_en = 1'b1;
                    wr_way    = hit_way;
                end else if (req) begin
                    next_state = victim_dirty ? WB_WORD0 : LOAD_WORD0;
                end else if (halt) begin
                    next_state = FLUSH_CHECK;
                end
            end
            WB_WORD0: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(victim_tag, idx, 1'b0);
                mem_store = victim_data0;
                if (xfer_done) begin
                    next_state = WB_WORD1;
                end
            end
            WB_WORD1: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(victim_tag, idx, 1'b1);
                mem_store = victim_data1;
                if (xfer_done) begin
                    next_state = LOAD_WORD0;
                end
            end
            LOAD_WORD0: begin
                mem_ren   = 1'b1;
                mem_addr  = block_addr(req_tag, idx, 1'b0);
                fill_word = 1'b0;
                if (xfer_done) begin
                    fill_en    = 1'b1;
                    next_state = LOAD_WORD1;
                end
            end
            LOAD_WORD1: begin
                // second word marks the frame valid
                mem_ren   = 1'b1;
                mem_addr  = block_addr(req_tag, idx, 1'b1);
                fill_word = 1'b1;
                if (xfer_done) begin
                    fill_en    = 1'b1;
                    next_state = IDLE;
                end
            end
            FLUSH_CHECK: begin
                if (flush_idx[4]) begin
                    next_state = HALTED;
                end else if (flush_dirty) begin
                    next_state = FLUSH_WORD0;
                end else begin
                    next_flush_idx = flush_idx + 5'd1;
                end
            end
            FLUSH_WORD0: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(flush_tag, flush_set, 1'b0);
                mem_store = flush_data0;
                if (xfer_done) begin
                    next_state = FLUSH_WORD1;
                end
            end
            FLUSH_WORD1: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(flush_tag, flush_set, 1'b1);
                mem_store = flush_data1;
                if (xfer_done) begin
                    flush_clean    = 1'b1;
                    next_flush_idx = flush_idx + 5'd1;
                    next_state     = FLUSH_CHECK;
                end
            end
            HALTED: begin
                // held until reset
                flushed = 1'b1;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* src/dcache_store.sv */
/*
 * data cache frame store
 *   valid, dirty and LRU bits under reset
 *   tag and data arrays for both ways of every set
 *   fill, CPU write and flush-clean write ports
 *   set read port for lookup, flush read port for the walk
 */

`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  idx_t         idx,
    input  tag_t         req_tag,
    input  blk_t         blk,
    input  logic         fill_en,
    input  blk_t         fill_word,
    input  word_t        fill_data,
    input  way_t         wr_way,
    input  logic         cpu_wr_en,
    input  logic         cpu_wr_is_read,
    input  word_t        dmem_store,
    input  flush_idx_t   flush_idx,
    input  logic         flush_clean,
    output logic [1:0]   set_valid,
    output logic [1:0]   set_dirty,
    output tag_t         set_tag0,
    output tag_t         set_tag1,
    output way_t         set_lru,
    output word_t [3:0]  set_data,
    output word_t        victim_data0,
    output word_t        victim_data1,
    output logic         flush_dirty,
    output tag_t         flush_tag,
    output word_t        flush_data0,
    output word_t        flush_data1
);

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    way_t                lru_q   [NUM_SETS];
    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    word_t               data_q  [NUM_SETS][NUM_WAYS][BLK_WORDS];

    idx_t flush_set;
    way_t flush_way;

    assign flush_set = flush_idx[2:0];
    assign flush_way = flush_idx[3];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            if (fill_en) begin
                // word 0 drops the old frame, word 1 completes the new one
                valid_q[idx][wr_way] <= fill_word;
                dirty_q[idx][wr_way] <= 1'b0;
            end
            if (cpu_wr_en) begin
                lru_q[idx] <= ~wr_way;
                if (!cpu_wr_is_read) begin
                    dirty_q[idx][wr_way] <= 1'b1;
                end
            end
            if (flush_clean) begin
                dirty_q[flush_set][flush_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            tag_q[idx][wr_way]             <= req_tag;
            data_q[idx][wr_way][fill_word] <= fill_data;
        end
        if (cpu_wr_en && !cpu_wr_is_read) begin
            data_q[idx][wr_way][blk] <= dmem_store;
        end
    end

    // selected set for lookup
    assign set_valid = valid_q[idx];
    assign set_dirty = dirty_q[idx];
    assign set_tag0  = tag_q[idx][0];
    assign set_tag1  = tag_q[idx][1];
    assign set_lru   = lru_q[idx];
    assign set_data  = {data_q[idx][1][1], data_q[idx][1][0],
                        data_q[idx][0][1], data_q[idx][0][0]};

    // LRU frame for write-back
    assign victim_data0 = data_q[idx][lru_q[idx]][0];
    assign victim_data1 = data_q[idx][lru_q[idx]][1];

    // frame under the flush walk
    assign flush_dirty = dirty_q[flush_set][flush_way];
    assign flush_tag   = tag_q[flush_set][flush_way];
    assign flush_data0 = data_q[flush_set][flush_way][0];
    assign flush_data1 = data_q[flush_set][flush_way][1];

endmodule

/* src/dcache_top.sv */
/*
 * data cache top level
 *   lookup, controller and frame store wired together
 *   CPU request port and plain memory port
 */

`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  word_t dmem_addr,
    input  word_t dmem_store,
    input  logic  halt,
    output logic  dhit,
    output word_t dmem_load,
    output logic  flushed,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_addr,
    output word_t mem_store,
    input  word_t mem_load,
    input  logic  mem_wait
);

    // set read port
    logic [1:0]  set_valid;
    logic [1:0]  set_dirty;
    tag_t        set_tag0;
    tag_t        set_tag1;
    way_t        set_lru;
    word_t [3:0] set_data;

    // lookup decisions
    logic        hit;
    way_t        hit_way;
    way_t        victim_way;
    logic        victim_dirty;
    tag_t        victim_tag;
    idx_t        idx;
    blk_t        blk;
    tag_t        req_tag;
    word_t       read_word;
    word_t       victim_data0;
    word_t       victim_data1;

    // store write strobes and flush port
    logic        fill_en;
    blk_t        fill_word;
    word_t       fill_data;
    logic        cpu_wr_en;
    logic        cpu_wr_is_read;
    way_t        wr_way;
    flush_idx_t  flush_idx;
    logic        flush_clean;
    logic        flush_dirty;
    tag_t        flush_tag;
    word_t       flush_data0;
    word_t       flush_data1;

    dcache_lookup u_lookup (.*);

    dcache_ctrl u_ctrl (.*);

    dcache_store u_store (.*);

endmodule

/* sim/dcache_asserts.sv */
/*
 * concurrent checks bound to the data cache top level
 *   one memory transfer direction at a time, word aligned
 *   no dhit during memory traffic
 *   flushed held once raised
 */

`timescale 1ns/1ps

module dcache_asserts import dcache_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    input logic  dhit,
    input logic  flushed,
    input logic  mem_ren,
    input logic  mem_wen,
    input word_t mem_addr
);

    int fail_count = 0;

    mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
    else begin
        $error("mem_ren and mem_wen high together");
        fail_count++;
    end

    // sticky until reset
    flushed_held: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
    else begin
        $error("flushed dropped without reset");
        fail_count++;
    end

    dhit_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |-> !(mem_ren || mem_wen))
    else begin
        $error("dhit raised during a memory transfer");
        fail_count++;
    end

    mem_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) |-> (mem_addr[1:0] == 2'b00))
    else begin
        $error("memory address not word aligned");
        fail_count++;
    end

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

/* sim/dcache_tb.sv */
/*
 * data cache testbench
 *   clock, reset and CPU request driver
 *   memory model with LFSR wait states
 *   cases file reader, value checker, watchdog and summary
 */

`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int    MAX_CASES  = 64;
    localparam int    CASE_LIMIT = 200;
    localparam word_t FILL_KEY   = 32'hC0DE_0000;

    logic  CLK;
    logic  nRST;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
    logic  dhit;
    word_t dmem_load;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_store;
    word_t mem_load;
    logic  mem_wait;

    // op, hit, address, store data, expected word
    logic [103:0] case_mem [MAX_CASES];
    word_t        model_mem [word_t];
    word_t        ref_mem [word_t];
    logic [15:0]  lfsr_state;
    int           n_cases;
    int           errors;
    int           failed_tests;

    dcache_top DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Galois LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]};
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    // two bits per transfer, 0 to 3 wait cycles
    function automatic int draw_wait();
        int cycles;
        cycles = 0;
        for (int b = 0; b < 2; b++) begin
            cycles = (cycles << 1) | int'(lfsr_step());
        end
        return cycles;
    endfunction

    function automatic word_t word_key(input word_t addr);
        return {addr[31:2], 2'b00};
    endfunction

    // untouched words hold their address xor a key
    function automatic word_t model_word(input word_t addr);
        word_t key;
        key = word_key(addr);
        if (model_mem.exists(key)) begin
            return model_mem[key];
        end
        return key ^ FILL_KEY;
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0: return "read";
            4'h1: return "write";
            4'h2: return "memory check";
            4'h3: return "halt";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic finish_test(input string label, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", label);
        end else begin
            $display("%s: FAILED", label);
            failed_tests++;
        end
    endtask

    task automatic check_quiet();
        check_value("dhit", word_t'(dhit), '0);
        check_value("mem_ren", word_t'(mem_ren), '0);
        check_value("mem_wen", word_t'(mem_wen), '0);
        check_value("flushed", word_t'(flushed), '0);
    endtask

    // hold the request until dhit, sampled mid cycle
    task automatic do_access(input logic is_write, input word_t addr, input word_t data,
                             output word_t load, output int traffic, output int wait_cycles);
        traffic     = 0;
        wait_cycles = 0;
        dmem_addr   = addr;
        dmem_store  = data;
        dmem_ren    = !is_write;
        dmem_wen    = is_write;
        #1;
        while (!dhit) begin
            if (mem_ren || mem_wen) begin
                traffic++;
            end
            wait_cycles++;
            @(negedge CLK);
            #1;
        end
        load = dmem_load;
        @(negedge CLK);
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    task automatic do_halt();
        halt = 1'b1;
        #1;
        while (!flushed) begin
            @(negedge CLK);
            #1;
        end
        foreach (ref_mem[a]) begin
            check_value($sformatf("mem[%h]", a), model_word(a), ref_mem[a]);
        end
        // cache stays quiet once flushed
        repeat (8) begin
            @(negedge CLK);
            #1;
            check_value("flushed", word_t'(flushed), 32'd1);
            check_value("mem request", word_t'(mem_ren || mem_wen), '0);
        end
    endtask

    initial begin : memory_model
        int wait_left;
        bit busy;
        lfsr_state = 16'd47939;
        mem_wait   = 1'b1;
        mem_load   = '0;
        busy       = 1'b0;
        wait_left  = 0;
        forever begin
            @(negedge CLK);
            if (!(mem_ren || mem_wen)) begin
                busy     = 1'b0;
                mem_wait = 1'b1;
            end else begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = draw_wait();
                end
                if (wait_left > 0) begin
                    mem_wait = 1'b1;
                    wait_left--;
                end else begin
                    // transfer completes on the coming rising edge
                    mem_wait = 1'b0;
                    mem_load = model_word(mem_addr);
                    if (mem_wen) begin
                        model_mem[word_key(mem_addr)] = mem_store;
                    end
                    busy = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat ((n_cases + 1) * CASE_LIMIT) @(posedge CLK);
        $display("timeout: the cache did not finish the cases within %0d cycles",
                 (n_cases + 1) * CASE_LIMIT);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        logic [103:0] entry;
        logic [3:0]   op;
        logic         want_hit;
        word_t        addr;
        word_t        data;
        word_t        want_word;
        word_t        load;
        int           traffic;
        int           wait_cycles;
        int           errors_before;
        string        label;

        nRST         = 1'b0;
        dmem_ren     = 1'b0;
        dmem_wen     = 1'b0;
        dmem_addr    = '0;
        dmem_store   = '0;
        halt         = 1'b0;
        errors       = 0;
        failed_tests = 0;
        for (int i = 0; i < MAX_CASES; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("sim/dcache_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[n_cases][103:100] != 4'hF) begin
            n_cases++;
        end

        repeat (4) begin
            @(posedge CLK);
            #1;
            check_quiet();
        end
        @(negedge CLK);
        nRST = 1'b1;
        #1;
        check_quiet();
        if (n_cases == 0) begin
            $display("no cases could be read from sim/dcache_cases.txt");
            errors++;
        end
        finish_test("reset", 0);

        for (int i = 0; i < n_cases; i++) begin
            entry         = case_mem[i];
            op            = entry[103:100];
            want_hit      = entry[96];
            addr          = entry[95:64];
            data          = entry[63:32];
            want_word     = entry[31:0];
            errors_before = errors;
            label         = $sformatf("case %0d %s %h", i + 1, op_name(op), addr);
            case (op)
                4'h0, 4'h1: begin
                    @(negedge CLK);
                    do_access(op == 4'h1, addr, data, load, traffic, wait_cycles);
                    if (op == 4'h0) begin
                        check_value("dmem_load", load, want_word);
                    end else begin
                        ref_mem[word_key(addr)] = data;
                    end
                    check_value("first-cycle hit", word_t'(wait_cycles == 0 && traffic == 0),
                                word_t'(want_hit));
                end
                4'h2: begin
                    check_value($sformatf("mem[%h]", addr), model_word(addr), want_word);
                end
                4'h3: begin
                    @(negedge CLK);
                    do_halt();
                end
                default: begin
                    $display("case %0d has an unknown operation code %h", i + 1, op);
                    errors++;
                end
            endcase
            finish_test(label, errors_before);
        end

        $display("%0d tests run, %0d ok, %0d with errors, %0d mismatches",
                 n_cases + 1, n_cases + 1 - failed_tests, failed_tests, errors);
        if (DUT.u_asserts.fail_count != 0) begin
            $display("bound assertions fired %0d times", DUT.u_asserts.fail_count);
        end
        if (failed_tests == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sim/dcache_cases.txt */
// columns: op _ hit _ address _ store data _ expected load or memory word, all hex
// op 0 read, 1 write, 2 memory word check, 3 halt; hit 1 means served without memory traffic
// set 0: fill, then hits on both words
0_0_00000000_00000000_c0de0000
0_1_00000004_00000000_c0de0004
0_1_00000000_00000000_c0de0000
// set 0: second tag sits beside the first, third tag evicts the LRU way
0_0_00000040_00000000_c0de0040
0_1_00000000_00000000_c0de0000
0_1_00000044_00000000_c0de0044
0_0_00000080_00000000_c0de0080
0_1_00000040_00000000_c0de0040
0_0_00000004_00000000_c0de0004
// write hit, write miss, read back
1_1_00000000_11111111_00000000
0_1_00000000_00000000_11111111
1_0_00000010_22222222_00000000
0_1_00000010_00000000_22222222
0_1_00000014_00000000_c0de0014
// set 3: three dirty tags force write-backs
1_0_00000018_33330018_00000000
1_0_0000005c_3333005c_00000000
1_0_0000009c_3333009c_00000000
2_0_00000018_00000000_33330018
2_0_0000001c_00000000_c0de001c
0_0_00000018_00000000_33330018
2_0_0000005c_00000000_3333005c
0_1_00000098_00000000_c0de0098
0_1_0000009c_00000000_3333009c
// full-width tag in set 4
1_0_12345020_44444444_00000000
0_1_12345024_00000000_d2ea5024
0_1_12345020_00000000_44444444
// halt flush, then memory holds the dirty words
3_0_00000000_00000000_00000000
2_0_00000000_00000000_11111111
2_0_00000004_00000000_c0de0004
2_0_00000010_00000000_22222222
2_0_0000009c_00000000_3333009c
2_0_12345020_00000000_44444444

/* compile.f */
src/dcache_pkg.sv
src/dcache_lookup.sv
src/dcache_ctrl.sv
src/dcache_store.sv
src/dcache_top.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the data cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dcache_tb -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vdcache_tb | tee /dev/stderr | grep "all tests passed" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
